/* hw/video_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// video package
// colour width and shared enums of the character video controller
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package video_pkg;

   localparam int COLOR_W = 4;  // colour index width

   // fetch sequencer states
   typedef enum logic [1:0] {
      FS_IDLE   = 2'd0,  // waiting for a display line
      FS_SCREEN = 2'd1,  // screen code read
      FS_CHAR   = 2'd2,  // bitmap byte read
      FS_HOLD   = 2'd3   // byte waits for the shifter
   } fetch_state_e;

   // memory port owners
   typedef enum logic [1:0] {
      OWN_NONE = 2'd0,
      OWN_VIC  = 2'd1,
      OWN_CPU  = 2'd2
   } bus_owner_e;

   // register map on adi
   typedef enum logic [5:0] {
      REG_VIDEO_BASE = 6'd0,
      REG_CHAR_BASE  = 6'd1,
      REG_FG         = 6'd2,
      REG_BG         = 6'd3,
      REG_RASTER_CMP = 6'd4,
      REG_IRQ_STATUS = 6'd5,
      REG_IRQ_ENABLE = 6'd6,
      REG_RASTER_Y   = 6'd7   // read only
   } reg_addr_e;

endpackage

`default_nettype wire

/* hw/raster_timer.sv */
////////////////////////////////////////////////////////////////////////////
// raster timer
// dot and line counters with line start and display window flags
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module raster_timer #(
   parameter int H_TOTAL = 96,
   parameter int V_TOTAL = 24,
   parameter int ROWS    = 2
) (
   input  wire        clk_dot4x,
   input  wire        rst_n,
   output logic [8:0] x,
   output logic [8:0] y,
   output logic       line_start,
   output logic       display_line
);

   logic last_dot;  // final dot of the line

   assign last_dot     = (x == 9'(H_TOTAL - 1));
   assign line_start   = (x == 9'd0);
   assign display_line = (y < 9'(ROWS * 8));  // character rows only

   always_ff @(posedge clk_dot4x or negedge rst_n) begin
      if (!rst_n) begin
         x <= '0;
         y <= '0;
      end else if (last_dot) begin
         x <= '0;
         y <= (y == 9'(V_TOTAL - 1)) ? 9'd0 : y + 9'd1;  // frame wrap
      end else begin
         x <= x + 9'd1;
      end
   end

   // dot counter never leaves the line
   a_x_range: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
      x < 9'(H_TOTAL));

   // every line start is followed by the next one a full line later
   a_line_period: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
      line_start |=> !line_start [* (H_TOTAL - 1)] ##1 line_start);

endmodule

`default_nettype wire

/* hw/register_file.sv */
////////////////////////////////////////////////////////////////////////////
// register file
// cpu visible registers, read mux and raster compare interrupt
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module register_file (
   input  wire                            clk_dot4x,
   input  wire                            rst_n,
   input  wire                            ce,          // low selects the chip
   input  wire                            rw,          // low is a write
   input  wire  [5:0]                     adi,
   input  wire  [7:0]                     dbi,
   input  wire                            line_start,
   input  wire  [8:0]                     y,
   output logic [7:0]                     dbo,
   output logic                           irq,         // active low
   output logic [3:0]                     video_base,
   output logic [2:0]                     char_base,
   output logic [video_pkg::COLOR_W-1:0]  fg,
   output logic [video_pkg::COLOR_W-1:0]  bg
);

   video_pkg::reg_addr_e sel;
   logic [7:0] raster_cmp;
   logic       irq_status;
   logic       irq_enable;
   logic       wr_en;
   logic       cmp_hit;

   assign sel     = video_pkg::reg_addr_e'(adi);
   assign wr_en   = !ce && !rw;
   assign cmp_hit = line_start && (y == {1'b0, raster_cmp});
   assign irq     = !(irq_status && irq_enable);

   always_ff @(posedge clk_dot4x or negedge rst_n) begin
      if (!rst_n) begin
         video_base <= '0;
         char_base  <= '0;
         fg         <= '0;
         bg         <= '0;
         raster_cmp <= '0;
         irq_status <= 1'b0;
         irq_enable <= 1'b0;
      end else begin
         if (wr_en) begin
            case (sel)
               video_pkg::REG_VIDEO_BASE: video_base <= dbi[3:0];
               video_pkg::REG_CHAR_BASE:  char_base  <= dbi[2:0];
               video_pkg::REG_FG:         fg         <= dbi[video_pkg::COLOR_W-1:0];
               video_pkg::REG_BG:         bg         <= dbi[video_pkg::COLOR_W-1:0];
               video_pkg::REG_RASTER_CMP: raster_cmp <= dbi;
               video_pkg::REG_IRQ_ENABLE: irq_enable <= dbi[0];
               default: ;  // status handled below, raster y is read only
            endcase
         end
         // a new match beats a clear in the same cycle
         if (cmp_hit)
            irq_status <= 1'b1;
         else if (wr_en && sel == video_pkg::REG_IRQ_STATUS && dbi[0])
            irq_status <= 1'b0;
      end
   end

   always_comb begin
      case (sel)
         video_pkg::REG_VIDEO_BASE: dbo = {4'd0, video_base};
         video_pkg::REG_CHAR_BASE:  dbo = {5'd0, char_base};
         video_pkg::REG_FG:         dbo = 8'(fg);
         video_pkg::REG_BG:         dbo = 8'(bg);
         video_pkg::REG_RASTER_CMP: dbo = raster_cmp;
         video_pkg::REG_IRQ_STATUS: dbo = {7'd0, irq_status};
         video_pkg::REG_IRQ_ENABLE: dbo = {7'd0, irq_enable};
         video_pkg::REG_RASTER_Y:   dbo = y[7:0];
         default:                   dbo = 8'd0;
      endcase
   end

endmodule

`default_nettype wire

/* hw/char_fetch.sv */
////////////////////////////////////////////////////////////////////////////
// character fetcher
// reads screen codes and bitmap bytes for each display line
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module char_fetch #(
   parameter int ADDR_W = 14,
   parameter int COLS   = 4
) (
   input  wire               clk_dot4x,
   input  wire               rst_n,
   input  wire               line_start,
   input  wire               display_line,
   input  wire  [8:0]        y,
   input  wire  [3:0]        video_base,
   input  wire  [2:0]        char_base,
   input  wire               fetch_ready,
   input  wire  [7:0]        fetch_rdata,
   input  wire               byte_ready,
   output logic              fetch_valid,
   output logic [ADDR_W-1:0] fetch_addr,
   output logic              byte_valid,
   output logic [7:0]        byte_data
);

   localparam int COL_W = (COLS > 1) ? $clog2(COLS) : 1;

   video_pkg::fetch_state_e state;
   logic [COL_W-1:0] col;       // column being fetched
   logic [8:0]       y_q;       // line, taken at line start
   logic [3:0]       vb_q;      // bases frozen for the whole line
   logic [2:0]       cb_q;
   logic [7:0]       code_q;    // screen code of this column
   logic             start;
   logic             last_col;

   assign start       = (state == video_pkg::FS_IDLE) && line_start && display_line;
   assign last_col    = (col == COL_W'(COLS - 1));
   assign fetch_valid = (state == video_pkg::FS_SCREEN) || (state == video_pkg::FS_CHAR);
   assign byte_valid  = (state == video_pkg::FS_HOLD);

   // screen matrix or character generator address
   always_comb begin
      if (state == video_pkg::FS_CHAR)
         fetch_addr = ADDR_W'({cb_q, 11'd0}) + ADDR_W'({code_q, 3'd0}) + ADDR_W'(y_q[2:0]);
      else
         fetch_addr = ADDR_W'({vb_q, 10'd0}) + ADDR_W'(y_q[8:3] * COLS) + ADDR_W'(col);
   end

   always_ff @(posedge clk_dot4x or negedge rst_n) begin
      if (!rst_n) begin
         state <= video_pkg::FS_IDLE;
         col   <= '0;
      end else begin
         case (state)
            video_pkg::FS_IDLE: begin
               if (start) begin
                  col   <= '0;
                  state <= video_pkg::FS_SCREEN;
               end
            end
            video_pkg::FS_SCREEN: begin
               if (fetch_ready)
                  state <= video_pkg::FS_CHAR;
            end
            video_pkg::FS_CHAR: begin
               if (fetch_ready)
                  state <= video_pkg::FS_HOLD;
            end
            default: begin  // FS_HOLD
               if (byte_ready) begin
                  col   <= col + 1'b1;
                  state <= last_col ? video_pkg::FS_IDLE : video_pkg::FS_SCREEN;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk_dot4x) begin
      if (start) begin
         y_q  <= y;
         vb_q <= video_base;
         cb_q <= char_base;
      end
      if (state == video_pkg::FS_SCREEN && fetch_ready)
         code_q <= fetch_rdata;
      if (state == video_pkg::FS_CHAR && fetch_ready)
         byte_data <= fetch_rdata;  // held through FS_HOLD
   end

   // a pending request keeps its address until the arbiter takes it
   a_req_stable: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
      fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch_addr));

endmodule

`default_nettype wire

/* hw/bus_arbiter.sv */
////////////////////////////////////////////////////////////////////////////
// bus arbiter
// shares the memory port, fetcher first, cpu after a stall limit
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter #(
   parameter int ADDR_W    = 14,
   parameter int STALL_MAX = 6
) (
   input  wire               clk_dot4x,
   input  wire               rst_n,
   input  wire               fetch_valid,
   input  wire  [ADDR_W-1:0] fetch_addr,
   input  wire               cpu_valid,
   input  wire  [ADDR_W-1:0] cpu_addr,
   input  wire               cpu_we,
   input  wire  [7:0]        cpu_wdata,
   input  wire               mem_ready,
   input  wire  [7:0]        mem_rdata,
   output logic              fetch_ready,
   output logic [7:0]        fetch_rdata,
   output logic              cpu_ready,
   output logic [7:0]        cpu_rdata,
   output logic              mem_valid,
   output logic [ADDR_W-1:0] mem_addr,
   output logic              mem_we,
   output logic [7:0]        mem_wdata,
   output logic              ba,          // low while the fetcher wants the bus
   output logic              aec          // high after a vic beat
);

   localparam int CNT_W = $clog2(STALL_MAX + 1);

   video_pkg::bus_owner_e grant;       // routed this cycle
   video_pkg::bus_owner_e last_owner;  // owner of the last beat
   logic [CNT_W-1:0] stall_cnt;        // cycles the cpu has waited
   logic             cpu_force;

   assign cpu_force = (stall_cnt == CNT_W'(STALL_MAX));

   always_comb begin
      if (fetch_valid && !(cpu_valid && cpu_force))
         grant = video_pkg::OWN_VIC;
      else if (cpu_valid)
         grant = video_pkg::OWN_CPU;
      else
         grant = video_pkg::OWN_NONE;
   end

   assign mem_valid   = (grant != video_pkg::OWN_NONE);
   assign mem_addr    = (grant == video_pkg::OWN_CPU) ? cpu_addr : fetch_addr;
   assign mem_we      = (grant == video_pkg::OWN_CPU) && cpu_we;  // fetcher only reads
   assign mem_wdata   = cpu_wdata;
   assign fetch_ready = (grant == video_pkg::OWN_VIC) && mem_ready;
   assign cpu_ready   = (grant == video_pkg::OWN_CPU) && mem_ready;
   assign fetch_rdata = mem_rdata;
   assign cpu_rdata   = mem_rdata;
   assign ba          = !fetch_valid;
   assign aec         = (last_owner == video_pkg::OWN_VIC);

   always_ff @(posedge clk_dot4x or negedge rst_n) begin
      if (!rst_n) begin
         stall_cnt  <= '0;
         last_owner <= video_pkg::OWN_NONE;
      end else begin
         if (!cpu_valid || cpu_ready)
            stall_cnt <= '0;
         else if (!cpu_force)
            stall_cnt <= stall_cnt + 1'b1;  // saturates at the limit
         if (mem_valid && mem_ready)
            last_owner <= grant;
      end
   end

   a_one_ready: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
      !(fetch_ready && cpu_ready));

endmodule

`default_nettype wire

/* hw/pixel_shifter.sv */
////////////////////////////////////////////////////////////////////////////
// pixel shifter
// turns bitmap bytes into colour pixels, msb first
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pixel_shifter (
   input  wire                            clk_dot4x,
   input  wire                            rst_n,
   input  wire                            byte_valid,
   input  wire  [7:0]                     byte_data,
   input  wire  [video_pkg::COLOR_W-1:0]  fg,
   input  wire  [video_pkg::COLOR_W-1:0]  bg,
   output logic                           byte_ready,
   output logic                           pixel_valid,
   output logic [video_pkg::COLOR_W-1:0]  pixel_color
);

   logic [7:0] shift_q;  // current pixel in bit 7
   logic [3:0] cnt_q;    // pixels still to send
   logic       load;

   assign byte_ready  = (cnt_q <= 4'd1);  // empty or on the last pixel
   assign load        = byte_valid && byte_ready;
   assign pixel_valid = (cnt_q != 4'd0);
   assign pixel_color = shift_q[7] ? fg : bg;

   always_ff @(posedge clk_dot4x or negedge rst_n) begin
      if (!rst_n)
         cnt_q <= '0;
      else if (load)
         cnt_q <= 4'd8;
      else if (cnt_q != 4'd0)
         cnt_q <= cnt_q - 4'd1;
   end

   always_ff @(posedge clk_dot4x) begin
      if (load)
         shift_q <= byte_data;
      else
         shift_q <= {shift_q[6:0], 1'b0};
   end

   // a byte offered to a busy shifter waits unchanged until taken
   a_byte_hold: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
      byte_valid && !byte_ready |=> byte_valid && $stable(byte_data));

endmodule

`default_nettype wire

/* hw/video_top.sv */
////////////////////////////////////////////////////////////////////////////
// video top
// character mode controller, raster, registers, fetch, arbiter, shifter
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module video_top #(
   parameter int ADDR_W    = 14,
   parameter int H_TOTAL   = 96,
   parameter int V_TOTAL   = 24,
   parameter int COLS      = 4,
   parameter int ROWS      = 2,
   parameter int STALL_MAX = 6
) (
   input  wire                            clk_dot4x,
   input  wire                            rst_n,
   input  wire                            ce,
   input  wire                            rw,
   input  wire  [5:0]                     adi,
   input  wire  [7:0]                     dbi,
   input  wire                            cpu_valid,
   input  wire  [ADDR_W-1:0]              cpu_addr,
   input  wire                            cpu_we,
   input  wire  [7:0]                     cpu_wdata,
   input  wire                            mem_ready,
   input  wire  [7:0]                     mem_rdata,
   output logic [7:0]                     dbo,
   output logic                           irq,
   output logic                           ba,
   output logic                           aec,
   output logic                           cpu_ready,
   output logic [7:0]                     cpu_rdata,
   output logic                           mem_valid,
   output logic [ADDR_W-1:0]              mem_addr,
   output logic                           mem_we,
   output logic [7:0]                     mem_wdata,
   output logic                           pixel_valid,
   output logic [video_pkg::COLOR_W-1:0]  pixel_color,
   output logic [8:0]                     raster_y
);

   logic                          line_start;
   logic                          display_line;
   logic [3:0]                    video_base;
   logic [2:0]                    char_base;
   logic [video_pkg::COLOR_W-1:0] fg;
   logic [video_pkg::COLOR_W-1:0] bg;
   logic                          fetch_valid;
   logic [ADDR_W-1:0]             fetch_addr;
   logic                          fetch_ready;
   logic [7:0]                    fetch_rdata;
   logic                          byte_valid;
   logic [7:0]                    byte_data;
   logic                          byte_ready;

   raster_timer #(.H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL), .ROWS(ROWS)) u_raster (
      .clk_dot4x(clk_dot4x), .rst_n(rst_n),
      .x(),                                   // dot position not needed here
      .y(raster_y), .line_start(line_start), .display_line(display_line)
   );

   register_file u_regs (
      .clk_dot4x(clk_dot4x), .rst_n(rst_n),
      .ce(ce), .rw(rw), .adi(adi), .dbi(dbi),
      .line_start(line_start), .y(raster_y),
      .dbo(dbo), .irq(irq),
      .video_base(video_base), .char_base(char_base), .fg(fg), .bg(bg)
   );

   char_fetch #(.ADDR_W(ADDR_W), .COLS(COLS)) u_fetch (
      .clk_dot4x(clk_dot4x), .rst_n(rst_n),
      .line_start(line_start), .display_line(display_line), .y(raster_y),
      .video_base(video_base), .char_base(char_base),
      .fetch_ready(fetch_ready), .fetch_rdata(fetch_rdata), .byte_ready(byte_ready),
      .fetch_valid(fetch_valid), .fetch_addr(fetch_addr),
      .byte_valid(byte_valid), .byte_data(byte_data)
   );

   bus_arbiter #(.ADDR_W(ADDR_W), .STALL_MAX(STALL_MAX)) u_arb (
      .clk_dot4x(clk_dot4x), .rst_n(rst_n),
      .fetch_valid(fetch_valid), .fetch_addr(fetch_addr),
      .cpu_valid(cpu_valid), .cpu_addr(cpu_addr), .cpu_we(cpu_we), .cpu_wdata(cpu_wdata),
      .mem_ready(mem_ready), .mem_rdata(mem_rdata),
      .fetch_ready(fetch_ready), .fetch_rdata(fetch_rdata),
      .cpu_ready(cpu_ready), .cpu_rdata(cpu_rdata),
      .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_we(mem_we), .mem_wdata(mem_wdata),
      .ba(ba), .aec(aec)
   );

   pixel_shifter u_shift (
      .clk_dot4x(clk_dot4x), .rst_n(rst_n),
      .byte_valid(byte_valid), .byte_data(byte_data), .fg(fg), .bg(bg),
      .byte_ready(byte_ready), .pixel_valid(pixel_valid), .pixel_color(pixel_color)
   );

endmodule

`default_nettype wire

/* tests/tb_video_top.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the character video controller
// memory model, cpu bus driver and directed tests
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_video_top;

   localparam int ADDR_W      = 14;
   localparam int H_TOTAL     = 96;
   localparam int V_TOTAL     = 24;
   localparam int COLS        = 4;
   localparam int ROWS        = 2;
   localparam int STALL_MAX   = 6;
   localparam int CW          = video_pkg::COLOR_W;
   localparam int MEM_SIZE    = 1 << ADDR_W;
   localparam int PIX_N       = COLS * 8;           // pixels of one display line
   localparam int CLK_PERIOD  = 40;
   localparam int RESET_CYC   = 5;
   localparam int FRAME_CYC   = H_TOTAL * V_TOTAL;
   localparam int LINE_LIMIT  = 2 * FRAME_CYC;      // longest wait for a raster event
   localparam int CPU_LIMIT   = 400;
   localparam int PIX_LIMIT   = 4 * H_TOTAL;
   localparam int IRQ_LINE    = 5;
   localparam int CPU_N       = 8;

   logic              clk_dot4x = 1'b0;
   logic              rst_n;
   logic              ce;
   logic              rw;
   logic [5:0]        adi;
   logic [7:0]        dbi;
   logic              cpu_valid;
   logic [ADDR_W-1:0] cpu_addr;
   logic              cpu_we;
   logic [7:0]        cpu_wdata;
   logic              mem_ready = 1'b0;
   logic [7:0]        mem_rdata;
   logic [7:0]        dbo;
   logic              irq;
   logic              ba;
   logic              aec;
   logic              cpu_ready;
   logic [7:0]        cpu_rdata;
   logic              mem_valid;
   logic [ADDR_W-1:0] mem_addr;
   logic              mem_we;
   logic [7:0]        mem_wdata;
   logic              pixel_valid;
   logic [CW-1:0]     pixel_color;
   logic [8:0]        raster_y;

   logic [7:0]    mem [0:MEM_SIZE-1];   // shared video and cpu memory
   logic [CW-1:0] captured [0:PIX_N-1];
   integer        seed = 32'h456ee526;
   int            ready_thresh = 6;     // ready when a 3 bit random value is below this
   int            guard_beats = 0;      // cpu beats taken while the fetcher waits
   int            errors;
   int            tests_run;
   int            tests_failed;

   video_top #(
      .ADDR_W(ADDR_W), .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL),
      .COLS(COLS), .ROWS(ROWS), .STALL_MAX(STALL_MAX)
   ) uut (
      .clk_dot4x(clk_dot4x), .rst_n(rst_n),
      .ce(ce), .rw(rw), .adi(adi), .dbi(dbi),
      .cpu_valid(cpu_valid), .cpu_addr(cpu_addr), .cpu_we(cpu_we), .cpu_wdata(cpu_wdata),
      .mem_ready(mem_ready), .mem_rdata(mem_rdata),
      .dbo(dbo), .irq(irq), .ba(ba), .aec(aec),
      .cpu_ready(cpu_ready), .cpu_rdata(cpu_rdata),
      .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_we(mem_we), .mem_wdata(mem_wdata),
      .pixel_valid(pixel_valid), .pixel_color(pixel_color), .raster_y(raster_y)
   );

   always #(CLK_PERIOD / 2) clk_dot4x = ~clk_dot4x;

   // memory answers in the handshake cycle, back-pressure is random
   assign mem_rdata = mem[mem_addr];

   always @(negedge clk_dot4x)
      mem_ready <= (int'($random(seed) & 32'h7) < ready_thresh);

   always @(posedge clk_dot4x)
      if (mem_valid && mem_ready && mem_we)
         mem[mem_addr] <= mem_wdata;

   always @(posedge clk_dot4x) begin
      if (rst_n && cpu_valid && cpu_ready && !ba)
         guard_beats <= guard_beats + 1;   // only the stall limit lets this happen
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic report_error(input string msg);
      $display("ERROR at %0t ns: %s", $time, msg);
      errors++;
   endtask

   task automatic finish_test(input string name, input int start_err);
      tests_run++;
      if (errors == start_err) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - start_err);
      end
   endtask

   task automatic reg_write(input logic [5:0] addr, input logic [7:0] data);
      @(negedge clk_dot4x);
      ce  = 1'b0;
      rw  = 1'b0;   // write on the next rising edge
      adi = addr;
      dbi = data;
      @(negedge clk_dot4x);
      ce = 1'b1;
      rw = 1'b1;
   endtask

   task automatic reg_read(input logic [5:0] addr, output logic [7:0] data);
      @(negedge clk_dot4x);
      ce  = 1'b0;
      rw  = 1'b1;
      adi = addr;
      @(posedge clk_dot4x);
      data = dbo;
      @(negedge clk_dot4x);
      ce = 1'b1;
   endtask

   task automatic cpu_mem_access(input logic [ADDR_W-1:0] addr, input logic we,
                                 input logic [7:0] wdata, output logic [7:0] rdata);
      int  waited;
      logic done;
      waited = 0;
      done   = 1'b0;
      rdata  = 8'h00;
      @(negedge clk_dot4x);
      cpu_valid = 1'b1;
      cpu_addr  = addr;
      cpu_we    = we;
      cpu_wdata = wdata;
      while (!done && waited < CPU_LIMIT) begin
         @(posedge clk_dot4x);
         waited++;
         if (cpu_ready) begin
            done  = 1'b1;
            rdata = cpu_rdata;   // valid in the handshake cycle
         end
      end
      if (!done)
         report_error($sformatf("cpu access to 0x%0h never got cpu_ready", addr));
      @(negedge clk_dot4x);
      if (done)
         check_value("aec after cpu beat", 32'(aec), 32'd0);   // cpu owned the last beat
      cpu_valid = 1'b0;
      cpu_we    = 1'b0;
   endtask

   // returns on the first edge of the line, while its line_start is high
   task automatic wait_raster_line(input int line);
      int waited;
      waited = 0;
      while (int'(raster_y) == line && waited < LINE_LIMIT) begin
         @(posedge clk_dot4x);
         waited++;
      end
      while (int'(raster_y) != line && waited < LINE_LIMIT) begin
         @(posedge clk_dot4x);
         waited++;
      end
      if (int'(raster_y) != line)
         report_error($sformatf("raster line %0d was never reached", line));
   endtask

   task automatic capture_pixels();
      int n;
      int waited;
      n      = 0;
      waited = 0;
      while (n < PIX_N && waited < PIX_LIMIT) begin
         @(posedge clk_dot4x);
         waited++;
         if (pixel_valid) begin
            captured[n] = pixel_color;
            n++;
         end
      end
      if (n < PIX_N)
         report_error($sformatf("pixel stream stopped after %0d of %0d pixels, fetcher in %s",
                                n, PIX_N, uut.u_fetch.state.name()));
   endtask

   // screen code, then bitmap row, then msb first bit to colour
   function automatic logic [CW-1:0] expected_pixel(input int line, input int idx,
                                                    input int vb, input int cb,
                                                    input logic [CW-1:0] fgc,
                                                    input logic [CW-1:0] bgc);
      int         code;
      logic [7:0] bits;
      code = int'(mem[ADDR_W'(vb * 1024 + (line / 8) * COLS + idx / 8)]);
      bits = mem[ADDR_W'(cb * 2048 + code * 8 + line % 8)];
      return bits[3'(7 - idx % 8)] ? fgc : bgc;
   endfunction

   task automatic after_reset();
      int         start_err;
      logic [7:0] val;
      start_err = errors;
      repeat (RESET_CYC) @(posedge clk_dot4x);
      check_value("irq", 32'(irq), 32'd1);       // sampled in the last reset cycle
      check_value("ba", 32'(ba), 32'd1);
      check_value("aec", 32'(aec), 32'd0);
      check_value("mem_valid", 32'(mem_valid), 32'd0);
      check_value("pixel_valid", 32'(pixel_valid), 32'd0);
      @(negedge clk_dot4x);
      rst_n = 1'b1;
      // status skipped, a compare value of 0 matches line 0 at once
      for (int a = 0; a < 8; a++) begin
         if (a != int'(video_pkg::REG_IRQ_STATUS)) begin
            reg_read(6'(a), val);
            check_value($sformatf("register %0d", a), 32'(val), 32'd0);
         end
      end
      finish_test("after reset", start_err);
   endtask

   task automatic write_readback(input logic [5:0] addr, input string name,
                                 input logic [7:0] data, input logic [7:0] mask);
      logic [7:0] val;
      reg_write(addr, data);
      reg_read(addr, val);
      check_value(name, 32'(val), 32'(data & mask));
   endtask

   task automatic register_access();
      int start_err;
      start_err = errors;
      write_readback(video_pkg::REG_FG, "REG_FG", 8'hA5, 8'((1 << CW) - 1));
      write_readback(video_pkg::REG_BG, "REG_BG", 8'h3C, 8'((1 << CW) - 1));
      write_readback(video_pkg::REG_VIDEO_BASE, "REG_VIDEO_BASE", 8'hF7, 8'h0F);
      write_readback(video_pkg::REG_CHAR_BASE, "REG_CHAR_BASE", 8'hFE, 8'h07);
      write_readback(video_pkg::REG_RASTER_CMP, "REG_RASTER_CMP", 8'h9A, 8'hFF);
      finish_test("register access", start_err);
   endtask

   task automatic stream_case(input int line, input int vb, input int cb,
                              input logic [CW-1:0] fgc, input logic [CW-1:0] bgc);
      reg_write(video_pkg::REG_VIDEO_BASE, 8'(vb));
      reg_write(video_pkg::REG_CHAR_BASE, 8'(cb));
      reg_write(video_pkg::REG_FG, 8'(fgc));
      reg_write(video_pkg::REG_BG, 8'(bgc));
      wait_raster_line(line);
      capture_pixels();
      check_value("aec after fetch", 32'(aec), 32'd1);   // no cpu beat so far
      for (int i = 0; i < PIX_N; i++)
         check_value($sformatf("pixel_color[%0d] line %0d", i, line), 32'(captured[i]),
                     32'(expected_pixel(line, i, vb, cb, fgc, bgc)));
   endtask

   task automatic pixel_stream();
      int start_err;
      start_err = errors;
      for (int i = 0; i < MEM_SIZE; i++)
         mem[ADDR_W'(i)] = 8'($random(seed));   // random codes and bitmaps
      stream_case(10, 2, 3, 4'hE, 4'h1);         // second row, bitmap row 2
      stream_case(3, 5, 6, 4'h7, 4'h9);
      finish_test("pixel stream", start_err);
   endtask

   task automatic raster_interrupt();
      int         start_err;
      int         waited;
      int         lows;
      logic [7:0] val;
      start_err = errors;
      lows      = 0;
      waited    = 0;
      reg_write(video_pkg::REG_RASTER_CMP, 8'(IRQ_LINE));
      reg_write(video_pkg::REG_IRQ_STATUS, 8'h01);   // drop stale matches
      reg_write(video_pkg::REG_IRQ_ENABLE, 8'h01);
      while (irq && waited < LINE_LIMIT) begin
         @(posedge clk_dot4x);
         waited++;
      end
      if (irq) begin
         report_error("irq never went low on the raster compare");
      end else begin
         reg_read(video_pkg::REG_RASTER_Y, val);
         check_value("REG_RASTER_Y", 32'(val), 32'(IRQ_LINE));
         reg_write(video_pkg::REG_IRQ_STATUS, 8'h01);
         @(posedge clk_dot4x);
         check_value("irq after clear", 32'(irq), 32'd1);
      end
      reg_write(video_pkg::REG_IRQ_ENABLE, 8'h00);
      repeat (FRAME_CYC + H_TOTAL) begin            // one full frame, match included
         @(posedge clk_dot4x);
         if (!irq)
            lows++;
      end
      check_value("irq low cycles while disabled", 32'(lows), 32'd0);
      reg_read(video_pkg::REG_IRQ_STATUS, val);
      check_value("REG_IRQ_STATUS while disabled", 32'(val), 32'd1);
      reg_write(video_pkg::REG_IRQ_STATUS, 8'h01);
      finish_test("raster interrupt", start_err);
   endtask

   task automatic cpu_during_fetch();
      int                start_err;
      int                waited;
      int                guard_start;
      logic [7:0]        wdata [0:CPU_N-1];
      logic [ADDR_W-1:0] addr;
      logic [7:0]        rd;
      start_err    = errors;
      waited       = 0;
      ready_thresh = 1;   // heavy back-pressure keeps fetch requests pending
      while (ba && waited < LINE_LIMIT) begin
         @(posedge clk_dot4x);
         waited++;
      end
      if (ba)
         report_error("ba never went low while a line was fetched");
      guard_start = guard_beats;
      for (int i = 0; i < CPU_N; i++) begin
         addr     = ADDR_W'(14'h3F00 + 14'(i * 5));
         wdata[i] = 8'($random(seed));
         cpu_mem_access(addr, 1'b1, wdata[i], rd);
      end
      for (int i = 0; i < CPU_N; i++) begin
         addr = ADDR_W'(14'h3F00 + 14'(i * 5));
         cpu_mem_access(addr, 1'b0, 8'h00, rd);
         check_value($sformatf("cpu_rdata[%0d]", i), 32'(rd), 32'(wdata[i]));
      end
      if (guard_beats == guard_start)
         report_error("no cpu access finished while the fetcher held ba low");
      ready_thresh = 6;
      finish_test("cpu access during fetch", start_err);
   endtask

   initial begin
      rst_n        = 1'b0;
      ce           = 1'b1;
      rw           = 1'b1;
      adi          = 6'd0;
      dbi          = 8'd0;
      cpu_valid    = 1'b0;
      cpu_addr     = '0;
      cpu_we       = 1'b0;
      cpu_wdata    = 8'd0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      for (int i = 0; i < MEM_SIZE; i++)
         mem[ADDR_W'(i)] = 8'(i ^ (i >> 8));   // every address bit shows up
      after_reset();
      register_access();
      pixel_stream();
      raster_interrupt();
      cpu_during_fetch();
      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* video_top.f */
hw/video_pkg.sv
hw/raster_timer.sv
hw/register_file.sv
hw/char_fetch.sv
hw/bus_arbiter.sv
hw/pixel_shifter.sv
hw/video_top.sv
tests/tb_video_top.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --assert -j 0
TOP       := tb_video_top
FILELIST  := video_top.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
